/* Makefile */
SRCS := $(shell cat uart_cmd_top.f)

obj_dir/Vtb_uart_cmd: uart_cmd_top.f $(SRCS)
	verilator --binary --assert --top-module tb_uart_cmd -f uart_cmd_top.f

run: obj_dir/Vtb_uart_cmd
	./obj_dir/Vtb_uart_cmd | tee sim.log
	grep -q "sim passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* testbench/tb_clk_gen.sv */
module tb_clk_gen (
  output logic clk
);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 time unit period
  end

endmodule

/* testbench/tb_uart_cmd.sv */
module tb_uart_cmd;

  localparam int TIMEOUT   = 1000;  // cycles allowed per wait loop
  localparam int BIT_CYC   = uart_cmd_pkg::BAUD_DIV;
  localparam int FRAME_CYC = uart_cmd_pkg::FRAME_BITS * uart_cmd_pkg::BAUD_DIV;

  logic                    clk;
  logic                    rst_n;
  uart_cmd_pkg::cmd_word_t cmd_in;
  logic                    cmd_vld;
  logic                    cmd_rdy;
  logic                    rx;
  logic                    tx;
  logic                    read_rdy;
  logic [7:0]              read_data;
  logic                    read_err;

  int         cycle = 0;
  int         rdy_cnt = 0;
  int         exp_frames = 0;
  bit         read_pending = 1'b0;
  bit         reply_corrupt = 1'b0;
  bit         line_busy = 1'b0;
  logic [7:0] exp_reply = 8'h00;
  bit         exp_err = 1'b0;
  logic [7:0] frame_q[$];  // every byte seen on tx
  int         start_q[$];  // cycle of each start edge on tx

  tb_clk_gen u_clk_gen (.clk(clk));

  uart_cmd_top u_uart_cmd_top (.*);

  task automatic halt_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic flag_mismatch(input string what);
    halt_run($sformatf("MISMATCH at time %0t: %s", $time, what));
  endtask

  always @(posedge clk)
    cycle <= cycle + 1;

  always @(negedge clk)
    if (read_rdy)
      rdy_cnt++;

  assert property (@(posedge clk) disable iff (!rst_n) (cmd_vld && cmd_rdy) |=> !cmd_rdy)
    else flag_mismatch("cmd_rdy still high on the cycle after acceptance");
  assert property (@(posedge clk) disable iff (!rst_n) !tx |-> !cmd_rdy)
    else flag_mismatch("cmd_rdy high while a frame is on tx");
  assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else flag_mismatch("read_rdy longer than one cycle");
  assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |-> (cmd_rdy && read_data == exp_reply && read_err == exp_err))
    else flag_mismatch("read result or cmd_rdy wrong at read_rdy");

  // decodes one frame on tx from the negedge that saw the start edge
  task automatic capture_frame();
    logic [7:0] data;
    logic       par;
    int         start_cycle;
    int         i;
    start_cycle = cycle;
    repeat (BIT_CYC / 2 - 1) @(negedge clk);
    assert (tx == 1'b0) else flag_mismatch("start bit not low at mid-bit");
    for (i = 0; i < 8; i++)
    begin
      repeat (BIT_CYC) @(negedge clk);
      data[i] = tx;  // lsb first
    end
    repeat (BIT_CYC) @(negedge clk);
    par = tx;
    assert (^{par, data} == 1'b1) else flag_mismatch("frame parity is not odd");
    repeat (BIT_CYC) @(negedge clk);
    assert (tx == 1'b1) else flag_mismatch("stop bit not high");
    frame_q.push_back(data);
    start_q.push_back(start_cycle);
  endtask

  task automatic send_reply(input logic [7:0] addr_byte);
    logic [11:0] bits;
    int          i;
    exp_reply = addr_byte ^ 8'h5A;
    exp_err   = reply_corrupt;
    bits      = {2'b11, ~^exp_reply ^ reply_corrupt, exp_reply, 1'b0};  // stop plus one idle bit
    repeat ($urandom_range(20, 2) * BIT_CYC) @(posedge clk);
    #10;
    for (i = 0; i < 12; i++)
    begin
      rx = bits[i];
      repeat (BIT_CYC) @(posedge clk);
      #10;
    end
  endtask

  // line responder
  initial
  begin
    rx = 1'b1;
    forever
    begin
      @(negedge clk);
      if (rst_n && !tx)
      begin
        line_busy = 1'b1;
        capture_frame();
        if (read_pending)
          send_reply(frame_q[$]);
        line_busy = 1'b0;
      end
    end
  end

  task automatic run_command(input logic [15:0] word, input bit corrupt, input bit pulses);
    uart_cmd_pkg::cmd_word_t cmd;
    int first;
    int rdy_before;
    int accept_cycle;
    int done_cycle;
    int n;
    cmd           = word;
    first         = frame_q.size();
    rdy_before    = rdy_cnt;
    read_pending  = ~cmd.fields.wr;
    reply_corrupt = corrupt;
    exp_frames   += cmd.fields.wr ? 2 : 1;
    assert (cmd_rdy) else halt_run("command port not ready before a new command");
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(posedge clk);
    #10;
    accept_cycle = cycle;
    cmd_vld      = 1'b0;
    n = 0;
    while (!cmd_rdy)
    begin
      if (n == TIMEOUT)
        halt_run("timeout waiting for the command to end");
      else
      begin
        if (pulses && $urandom_range(7, 0) == 0)
        begin
          cmd_in  = 16'($urandom);
          cmd_vld = 1'b1;  // must be ignored while busy
        end
        @(posedge clk);
        #10;
        cmd_vld = 1'b0;
        n++;
      end
    end
    done_cycle = cycle;
    n = 0;
    while (line_busy)
    begin
      if (n == TIMEOUT)
        halt_run("timeout waiting for the line to go idle");
      else
      begin
        @(negedge clk);
        n++;
      end
    end
    assert (start_q.size() > first && start_q[first] == accept_cycle + 2)
      else flag_mismatch("first start bit not 2 cycles after acceptance");
    if (cmd.fields.wr)
    begin
      assert (frame_q.size() == first + 2) else flag_mismatch("write did not send two frames");
      assert (frame_q[first] == cmd.bytes.lo && frame_q[first + 1] == cmd.bytes.hi)
        else flag_mismatch($sformatf("write bytes %h %h, expected %h %h",
          frame_q[first], frame_q[first + 1], cmd.bytes.lo, cmd.bytes.hi));
      assert (start_q[first + 1] - start_q[first] - FRAME_CYC >= uart_cmd_pkg::GAP_CYCLES)
        else flag_mismatch("idle gap between write frames too short");
      assert (done_cycle == start_q[first + 1] + FRAME_CYC + 1)
        else flag_mismatch("cmd_rdy not back on the cycle after the last stop bit");
      assert (rdy_cnt == rdy_before) else flag_mismatch("read_rdy pulsed during a write");
    end
    else
    begin
      assert (frame_q.size() == first + 1 && frame_q[first] == cmd.bytes.hi)
        else flag_mismatch("read did not send exactly one address frame");
      assert (rdy_cnt == rdy_before + 1) else flag_mismatch("read_rdy did not pulse once");
      assert (read_data == (cmd.bytes.hi ^ 8'h5A) && read_err == corrupt)  // held after the pulse
        else flag_mismatch($sformatf("read gave %h err %b", read_data, read_err));
    end
    read_pending = 1'b0;
    @(posedge clk);
    #10;
  endtask

  initial
  begin
    int i;
    int n;
    void'($urandom(28));
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    repeat (3) @(posedge clk);
    #10;
    rst_n = 1'b1;
    @(posedge clk);
    #10;
    assert (tx && cmd_rdy && !read_rdy && !read_err)
      else flag_mismatch("outputs not at their reset values");
    run_command(16'hA53C, 1'b0, 1'b1);  // write of 3c then a5 on the line
    run_command(16'h2B77, 1'b0, 1'b0);  // read of address 2b
    run_command(16'h4D00, 1'b1, 1'b1);  // reply with bad parity
    for (i = 0; i < 40; i++)
      run_command(16'($urandom), $urandom_range(3, 0) == 0, 1'b1);
    repeat (2 * FRAME_CYC) @(negedge clk);  // room for a stray frame to start
    n = 0;
    while (line_busy)
    begin
      if (n == TIMEOUT)
        halt_run("timeout waiting for a stray frame to end");
      else
      begin
        @(negedge clk);
        n++;
      end
    end
    assert (frame_q.size() == exp_frames) else flag_mismatch("total frame count wrong");
    $display("sim passed");
    $finish;
  end

endmodule

/* uart_cmd_top.f */
verilog/uart_cmd_pkg.sv
verilog/uart_rx_frame.sv
verilog/uart_cmd_seq.sv
verilog/uart_tx_frame.sv
verilog/uart_cmd_top.sv
testbench/tb_clk_gen.sv
testbench/tb_uart_cmd.sv

/* verilog/uart_cmd_pkg.sv */
package uart_cmd_pkg;

  localparam int unsigned BAUD_DIV   = 8;   // clk cycles per serial bit
  localparam int unsigned FRAME_BITS = 11;  // start, 8 data, parity, stop
  localparam int unsigned GAP_CYCLES = 16;  // idle line time between two frames of a write

  localparam int unsigned BAUD_CNT_W = $clog2(BAUD_DIV);
  localparam int unsigned BIT_CNT_W  = $clog2(FRAME_BITS);
  localparam int unsigned GAP_CNT_W  = $clog2(GAP_CYCLES);

  // four of the gap cycles go to the wait, zero check, send and sender load steps
  localparam logic [GAP_CNT_W-1:0] GAP_LOAD = GAP_CNT_W'(GAP_CYCLES - 4);

  localparam int unsigned STATE_W = 3;

  localparam logic [STATE_W-1:0] ST_IDLE       = 3'd0;
  localparam logic [STATE_W-1:0] ST_SEND_LO    = 3'd1;
  localparam logic [STATE_W-1:0] ST_WAIT_LO    = 3'd2;
  localparam logic [STATE_W-1:0] ST_GAP        = 3'd3;
  localparam logic [STATE_W-1:0] ST_SEND_HI    = 3'd4;
  localparam logic [STATE_W-1:0] ST_WAIT_HI    = 3'd5;
  localparam logic [STATE_W-1:0] ST_WAIT_REPLY = 3'd6;

  // host command word, seen as two line bytes or as command fields
  typedef union packed {
    struct packed {
      logic [7:0] hi;
      logic [7:0] lo;
    } bytes;
    struct packed {
      logic       wr;    // 1 write, 0 read
      logic [6:0] addr;
      logic [7:0] data;
    } fields;
  } cmd_word_t;

endpackage

/* verilog/uart_cmd_seq.sv */
module uart_cmd_seq (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::cmd_word_t cmd_in,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  output logic                    tx_start,
  output logic [7:0]              tx_byte,
  input  logic                    tx_busy,
  input  logic [7:0]              rx_byte,
  input  logic                    rx_valid,
  input  logic                    rx_perr,
  output logic                    read_rdy,
  output logic [7:0]              read_data,
  output logic                    read_err
);

  logic [uart_cmd_pkg::STATE_W-1:0]   state;
  uart_cmd_pkg::cmd_word_t            cmd_q;
  logic [uart_cmd_pkg::GAP_CNT_W-1:0] gap_cnt;
  logic                               accept;
  logic                               tx_done;
  logic                               reply;

  assign cmd_rdy = (state == uart_cmd_pkg::ST_IDLE);
  assign accept  = cmd_vld & cmd_rdy;
  assign tx_done = ~tx_busy & ~tx_start;  // start pulse is still in flight one cycle
  assign reply   = (state == uart_cmd_pkg::ST_WAIT_REPLY) & rx_valid;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= uart_cmd_pkg::ST_IDLE;
      tx_start <= 1'b0;
      gap_cnt  <= '0;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        uart_cmd_pkg::ST_IDLE:
        begin
          if (accept)
            state <= cmd_in.fields.wr ? uart_cmd_pkg::ST_SEND_LO : uart_cmd_pkg::ST_SEND_HI;
        end
        uart_cmd_pkg::ST_SEND_LO:
        begin
          tx_start <= 1'b1;
          state    <= uart_cmd_pkg::ST_WAIT_LO;
        end
        uart_cmd_pkg::ST_WAIT_LO:
        begin
          if (tx_done)
          begin
            gap_cnt <= uart_cmd_pkg::GAP_LOAD;
            state   <= uart_cmd_pkg::ST_GAP;
          end
        end
        uart_cmd_pkg::ST_GAP:
        begin
          if (gap_cnt == '0)
            state <= uart_cmd_pkg::ST_SEND_HI;
          else
            gap_cnt <= gap_cnt - 1'b1;
        end
        uart_cmd_pkg::ST_SEND_HI:
        begin
          tx_start <= 1'b1;
          state    <= uart_cmd_pkg::ST_WAIT_HI;
        end
        uart_cmd_pkg::ST_WAIT_HI:
        begin
          if (tx_done)
            state <= cmd_q.fields.wr ? uart_cmd_pkg::ST_IDLE : uart_cmd_pkg::ST_WAIT_REPLY;
        end
        uart_cmd_pkg::ST_WAIT_REPLY:
        begin
          if (rx_valid)  // no timeout, a lost reply hangs until reset
          begin
            read_rdy <= 1'b1;
            read_err <= rx_perr;
            state    <= uart_cmd_pkg::ST_IDLE;
          end
        end
        default:
          state <= uart_cmd_pkg::ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_q <= cmd_in;
    if (state == uart_cmd_pkg::ST_SEND_LO)
      tx_byte <= cmd_q.bytes.lo;
    else if (state == uart_cmd_pkg::ST_SEND_HI)
      tx_byte <= cmd_q.bytes.hi;  // wr flag and addr for a read
    if (reply)
      read_data <= rx_byte;
  end

endmodule

/* verilog/uart_cmd_top.sv */
module uart_cmd_top (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::cmd_word_t cmd_in,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  input  logic                    rx,
  output logic                    tx,
  output logic                    read_rdy,
  output logic [7:0]              read_data,
  output logic                    read_err
);

  logic       tx_start;
  logic [7:0] tx_byte;
  logic       tx_busy;
  logic [7:0] rx_byte;
  logic       rx_valid;
  logic       rx_perr;

  uart_rx_frame u_rx_frame (
    .clk   (clk),
    .rst_n (rst_n),
    .rx    (rx),
    .data  (rx_byte),
    .valid (rx_valid),
    .perr  (rx_perr)
  );

  uart_cmd_seq u_cmd_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_byte   (tx_byte),
    .tx_busy   (tx_busy),
    .rx_byte   (rx_byte),
    .rx_valid  (rx_valid),
    .rx_perr   (rx_perr),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx_frame u_tx_frame (
    .clk   (clk),
    .rst_n (rst_n),
    .start (tx_start),
    .data  (tx_byte),
    .busy  (tx_busy),
    .tx    (tx)
  );

endmodule

/* verilog/uart_rx_frame.sv */
module uart_rx_frame (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic [7:0] data,
  output logic       valid,
  output logic       perr
);

  logic                                rx_meta;
  logic                                rx_sync;
  logic                                rx_prev;
  logic                                active;
  logic [uart_cmd_pkg::BAUD_CNT_W-1:0] baud_cnt;
  logic [uart_cmd_pkg::BIT_CNT_W-1:0]  bit_cnt;
  logic [8:0]                          shreg;    // data then parity, lsb first
  logic                                start_fall;
  logic                                sample;
  logic                                in_start;
  logic                                in_stop;

  assign start_fall = rx_prev & ~rx_sync;
  assign in_start   = (bit_cnt == '0);
  assign in_stop    = (bit_cnt == uart_cmd_pkg::BIT_CNT_W'(uart_cmd_pkg::FRAME_BITS - 1));

  // start bit is checked after half a bit, every later bit one full bit on
  assign sample = active & (in_start ?
    (baud_cnt == uart_cmd_pkg::BAUD_CNT_W'(uart_cmd_pkg::BAUD_DIV / 2 - 1)) :
    (baud_cnt == uart_cmd_pkg::BAUD_CNT_W'(uart_cmd_pkg::BAUD_DIV - 1)));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta  <= 1'b1;
      rx_sync  <= 1'b1;
      rx_prev  <= 1'b1;
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      valid    <= 1'b0;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
      valid   <= 1'b0;
      if (!active)
      begin
        if (start_fall)
        begin
          active   <= 1'b1;
          baud_cnt <= '0;
          bit_cnt  <= '0;
        end
      end
      else if (sample)
      begin
        baud_cnt <= '0;
        if (in_start && rx_sync)
          active <= 1'b0;  // glitch, not a real start bit
        else if (in_stop)
        begin
          active <= 1'b0;
          valid  <= 1'b1;
        end
        else
          bit_cnt <= bit_cnt + 1'b1;
      end
      else
        baud_cnt <= baud_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample && !in_start && !in_stop)
      shreg <= {rx_sync, shreg[8:1]};
    if (sample && in_stop)
    begin
      data <= shreg[7:0];
      perr <= ~^shreg;  // odd count of ones expected
    end
  end

endmodule

/* verilog/uart_tx_frame.sv */
module uart_tx_frame (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       start,
  input  logic [7:0] data,
  output logic       busy,
  output logic       tx
);

  logic [uart_cmd_pkg::BAUD_CNT_W-1:0] baud_cnt;
  logic [uart_cmd_pkg::BIT_CNT_W-1:0]  bit_cnt;
  logic [uart_cmd_pkg::FRAME_BITS-2:0] shreg;  // data, parity, stop
  logic                                parity;
  logic                                load;
  logic                                bit_end;
  logic                                last_bit;

  assign parity   = ~^data;  // odd parity over data plus parity bit
  assign load     = start & ~busy;
  assign bit_end  = busy & (baud_cnt == uart_cmd_pkg::BAUD_CNT_W'(uart_cmd_pkg::BAUD_DIV - 1));
  assign last_bit = (bit_cnt == uart_cmd_pkg::BIT_CNT_W'(uart_cmd_pkg::FRAME_BITS - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      tx       <= 1'b1;  // line idles high
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (load)
    begin
      busy     <= 1'b1;
      tx       <= 1'b0;  // start bit
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (last_bit)
      begin
        busy <= 1'b0;
        tx   <= 1'b1;
      end
      else
      begin
        tx      <= shreg[0];
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
    else if (busy)
      baud_cnt <= baud_cnt + 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (load)
      shreg <= {1'b1, parity, data};
    else if (bit_end)
      shreg <= {1'b1, shreg[uart_cmd_pkg::FRAME_BITS-2:1]};
  end

endmodule
